/* hdl/wbPkg.sv */
// Shared widths, lane indices and the completion record kind
// for the writeback stage.
`default_nettype none

package wbPkg;

        // ------------------------------
        // lane layout
        // ------------------------------
        localparam int NUM_LANES = 4;
        localparam int BRANCH_LANE = 2;
        localparam int LSU_LANE = 3;

        // ------------------------------
        // widths
        // ------------------------------
        localparam int CHECKPOINTS = 4;
        localparam int CHECKPOINTS_LOG = 2;
        localparam int SIZE_DATA = 32;
        localparam int SIZE_PC = 32;
        localparam int SIZE_PHYS_LOG = 6;
        localparam int SIZE_AL_LOG = 5;

        // kind of record sent to the active list.
        typedef enum logic [1:0]
        {
                CMPL_NORMAL = 2'd0,
                CMPL_BRANCH_OK = 2'd1,
                CMPL_MISPREDICT = 2'd2
        } cmplKind_e;

endpackage

`default_nettype wire

/* hdl/wbLane.sv */
// One writeback lane with its result register, squash check, bypass and
// writeback outputs.
`timescale 1ns/1ps
`default_nettype none

module wbLane
(
        input wire clk,
        input wire reset,
        input wire exeValid_i,
        input wire [wbPkg::CHECKPOINTS-1:0] exeBranchMask_i,
        input wire exeWritesReg_i,
        input wire [wbPkg::SIZE_PHYS_LOG-1:0] exeDestPhys_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] exeAlIndex_i,
        input wire [wbPkg::SIZE_DATA-1:0] exeData_i,
        input wire squash_i,
        input wire [wbPkg::CHECKPOINTS_LOG-1:0] squashCheckpoint_i,
        output logic writebkValid_o,
        output logic bypassValid_o,
        output logic [wbPkg::SIZE_PHYS_LOG-1:0] bypassPhys_o,
        output logic [wbPkg::SIZE_DATA-1:0] bypassData_o,
        output logic [wbPkg::SIZE_AL_LOG-1:0] alIndex_o
);

        logic validQ;
        logic [wbPkg::CHECKPOINTS-1:0] maskQ;
        logic writesRegQ;
        logic kill;

        always_ff @(posedge clk)
        begin
                if (reset)
                        validQ <= 1'b0;
                else
                        validQ <= exeValid_i;
        end

        always_ff @(posedge clk)
        begin
                maskQ <= exeBranchMask_i;
                writesRegQ <= exeWritesReg_i;
                bypassPhys_o <= exeDestPhys_i;
                bypassData_o <= exeData_i;
                alIndex_o <= exeAlIndex_i;
        end

        // the packet depends on the mispredicted checkpoint, so it dies here.
        assign kill = squash_i & maskQ[squashCheckpoint_i];

        assign writebkValid_o = validQ & ~kill;
        assign bypassValid_o = writebkValid_o & writesRegQ;

        // a valid packet under squash must carry a known branch mask.
        assert property (@(posedge clk) disable iff (reset)
                (validQ && squash_i) |-> !$isunknown(maskQ));

endmodule

`default_nettype wire

/* hdl/branchResolve.sv */
// Branch lane register, mispredict detection and checkpoint broadcast.
`timescale 1ns/1ps
`default_nettype none

module branchResolve
(
        input wire clk,
        input wire reset,
        input wire brValid_i,
        input wire [wbPkg::CHECKPOINTS_LOG-1:0] brCheckpoint_i,
        input wire brTaken_i,
        input wire [wbPkg::SIZE_PC-1:0] brTarget_i,
        input wire brPredTaken_i,
        input wire [wbPkg::SIZE_PC-1:0] brPredTarget_i,
        output logic ctrlVerified_o,
        output logic ctrlMispredict_o,
        output logic [wbPkg::CHECKPOINTS_LOG-1:0] ctrlCheckpoint_o,
        output logic [wbPkg::SIZE_PC-1:0] ctrlTarget_o,
        output logic ctrlTaken_o
);

        logic predTakenQ;
        logic [wbPkg::SIZE_PC-1:0] predTargetQ;
        logic dirWrong;
        logic targetWrong;

        always_ff @(posedge clk)
        begin
                if (reset)
                        ctrlVerified_o <= 1'b0;
                else
                        ctrlVerified_o <= brValid_i;
        end

        always_ff @(posedge clk)
        begin
                ctrlCheckpoint_o <= brCheckpoint_i;
                ctrlTaken_o <= brTaken_i;
                ctrlTarget_o <= brTarget_i;
                predTakenQ <= brPredTaken_i;
                predTargetQ <= brPredTarget_i;
        end

        // a wrong target only matters when both sides agree on taken.
        assign dirWrong = ctrlTaken_o ^ predTakenQ;
        assign targetWrong = ctrlTaken_o & predTakenQ & (ctrlTarget_o != predTargetQ);
        assign ctrlMispredict_o = ctrlVerified_o & (dirWrong | targetWrong);

        // a broadcast mispredict has to name a known checkpoint.
        assert property (@(posedge clk) disable iff (reset)
                ctrlMispredict_o |-> !$isunknown(ctrlCheckpoint_o));

endmodule

`default_nettype wire

/* hdl/completionQueue.sv */
// Multi-write completion FIFO with a credit counter toward the active list.
`timescale 1ns/1ps
`default_nettype none

module completionQueue
#(
        parameter int QUEUE_DEPTH = 8,
        parameter int INIT_CREDITS = 4
)
(
        input wire clk,
        input wire reset,
        input wire [wbPkg::NUM_LANES-1:0] laneValid_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] laneAlIndex0_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] laneAlIndex1_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] laneAlIndex2_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] laneAlIndex3_i,
        input wire brMispredict_i,
        input wire creditReturn_i,
        output logic cmplValid_o,
        output logic [wbPkg::SIZE_AL_LOG-1:0] cmplAlIndex_o,
        output wbPkg::cmplKind_e cmplKind_o
);

        // pointers wrap naturally, so QUEUE_DEPTH is a power of two.
        localparam int PTR_W = $clog2(QUEUE_DEPTH);
        localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
        localparam int CRED_W = $clog2(INIT_CREDITS + 1);
        localparam int WR_W = $clog2(wbPkg::NUM_LANES + 1);

        logic [wbPkg::SIZE_AL_LOG-1:0] alMem [QUEUE_DEPTH];
        wbPkg::cmplKind_e kindMem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wrPtr;
        logic [PTR_W-1:0] rdPtr;
        logic [CNT_W-1:0] count;
        logic [CRED_W-1:0] credits;
        logic [wbPkg::SIZE_AL_LOG-1:0] laneAl [wbPkg::NUM_LANES];
        wbPkg::cmplKind_e laneKind [wbPkg::NUM_LANES];
        logic [PTR_W-1:0] wrSlot [wbPkg::NUM_LANES];
        logic [WR_W-1:0] wrCount;

        assign laneAl[0] = laneAlIndex0_i;
        assign laneAl[1] = laneAlIndex1_i;
        assign laneAl[2] = laneAlIndex2_i;
        assign laneAl[3] = laneAlIndex3_i;

        // ------------------------------
        // write packing
        // ------------------------------
        always_comb
        begin
                wrCount = '0;
                for (int i = 0; i < wbPkg::NUM_LANES; i++)
                begin
                        wrSlot[i] = wrPtr + PTR_W'(wrCount);
                        wrCount = wrCount + WR_W'(laneValid_i[i]);
                        if (i == wbPkg::BRANCH_LANE)
                                laneKind[i] = brMispredict_i ? wbPkg::CMPL_MISPREDICT
                                                             : wbPkg::CMPL_BRANCH_OK;
                        else
                                laneKind[i] = wbPkg::CMPL_NORMAL;
                end
        end

        always_ff @(posedge clk)
        begin
                for (int i = 0; i < wbPkg::NUM_LANES; i++)
                begin
                        if (laneValid_i[i])
                        begin
                                alMem[wrSlot[i]] <= laneAl[i];
                                kindMem[wrSlot[i]] <= laneKind[i];
                        end
                end
        end

        // ------------------------------
        // pointers and credits
        // ------------------------------
        assign cmplValid_o = (count != '0) && (credits != '0);
        assign cmplAlIndex_o = alMem[rdPtr];
        assign cmplKind_o = kindMem[rdPtr];

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                        count <= '0;
                        credits <= CRED_W'(INIT_CREDITS);
                end
                else
                begin
                        wrPtr <= wrPtr + PTR_W'(wrCount);
                        rdPtr <= rdPtr + PTR_W'(cmplValid_o);
                        count <= count + CNT_W'(wrCount) - CNT_W'(cmplValid_o);
                        credits <= credits + CRED_W'(creditReturn_i) - CRED_W'(cmplValid_o);
                end
        end

        // execution is never stalled, so the queue has to absorb every burst.
        assert property (@(posedge clk) disable iff (reset)
                (int'(count) + int'(wrCount)) <= QUEUE_DEPTH);

        // the active list returns no more credits than it was given.
        assert property (@(posedge clk) disable iff (reset)
                int'(credits) <= INIT_CREDITS);

endmodule

`default_nettype wire

/* hdl/writeBack.sv */
// Writeback stage top with four result lanes, the branch resolver and the
// completion queue toward the active list.
`timescale 1ns/1ps
`default_nettype none

module writeBack
#(
        parameter int QUEUE_DEPTH = 8,
        parameter int INIT_CREDITS = 4
)
(
        input wire clk,
        input wire reset,
        input wire exeValid0_i,
        input wire [wbPkg::CHECKPOINTS-1:0] exeBranchMask0_i,
        input wire exeWritesReg0_i,
        input wire [wbPkg::SIZE_PHYS_LOG-1:0] exeDestPhys0_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] exeAlIndex0_i,
        input wire [wbPkg::SIZE_DATA-1:0] exeData0_i,
        input wire exeValid1_i,
        input wire [wbPkg::CHECKPOINTS-1:0] exeBranchMask1_i,
        input wire exeWritesReg1_i,
        input wire [wbPkg::SIZE_PHYS_LOG-1:0] exeDestPhys1_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] exeAlIndex1_i,
        input wire [wbPkg::SIZE_DATA-1:0] exeData1_i,
        input wire exeValid2_i,
        input wire [wbPkg::CHECKPOINTS-1:0] exeBranchMask2_i,
        input wire exeWritesReg2_i,
        input wire [wbPkg::SIZE_PHYS_LOG-1:0] exeDestPhys2_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] exeAlIndex2_i,
        input wire [wbPkg::SIZE_DATA-1:0] exeData2_i,
        input wire exeValid3_i,
        input wire [wbPkg::CHECKPOINTS-1:0] exeBranchMask3_i,
        input wire exeWritesReg3_i,
        input wire [wbPkg::SIZE_PHYS_LOG-1:0] exeDestPhys3_i,
        input wire [wbPkg::SIZE_AL_LOG-1:0] exeAlIndex3_i,
        input wire [wbPkg::SIZE_DATA-1:0] exeData3_i,
        input wire [wbPkg::CHECKPOINTS_LOG-1:0] brCheckpoint_i,
        input wire brTaken_i,
        input wire [wbPkg::SIZE_PC-1:0] brTarget_i,
        input wire brPredTaken_i,
        input wire [wbPkg::SIZE_PC-1:0] brPredTarget_i,
        input wire creditReturn_i,
        output logic bypassValid0_o,
        output logic [wbPkg::SIZE_PHYS_LOG-1:0] bypassPhys0_o,
        output logic [wbPkg::SIZE_DATA-1:0] bypassData0_o,
        output logic writebkValid0_o,
        output logic bypassValid1_o,
        output logic [wbPkg::SIZE_PHYS_LOG-1:0] bypassPhys1_o,
        output logic [wbPkg::SIZE_DATA-1:0] bypassData1_o,
        output logic writebkValid1_o,
        output logic bypassValid2_o,
        output logic [wbPkg::SIZE_PHYS_LOG-1:0] bypassPhys2_o,
        output logic [wbPkg::SIZE_DATA-1:0] bypassData2_o,
        output logic writebkValid2_o,
        output logic bypassValid3_o,
        output logic [wbPkg::SIZE_PHYS_LOG-1:0] bypassPhys3_o,
        output logic [wbPkg::SIZE_DATA-1:0] bypassData3_o,
        output logic writebkValid3_o,
        output logic ctrlVerified_o,
        output logic ctrlMispredict_o,
        output logic [wbPkg::CHECKPOINTS_LOG-1:0] ctrlCheckpoint_o,
        output logic [wbPkg::SIZE_PC-1:0] ctrlTarget_o,
        output logic ctrlTaken_o,
        output logic cmplValid_o,
        output logic [wbPkg::SIZE_AL_LOG-1:0] cmplAlIndex_o,
        output wbPkg::cmplKind_e cmplKind_o
);

        logic [wbPkg::SIZE_AL_LOG-1:0] alIndex0;
        logic [wbPkg::SIZE_AL_LOG-1:0] alIndex1;
        logic [wbPkg::SIZE_AL_LOG-1:0] alIndex2;
        logic [wbPkg::SIZE_AL_LOG-1:0] alIndex3;

        // ------------------------------
        // result lanes
        // ------------------------------
        wbLane lane0
        (
                .clk(clk), .reset(reset),
                .exeValid_i(exeValid0_i), .exeBranchMask_i(exeBranchMask0_i),
                .exeWritesReg_i(exeWritesReg0_i), .exeDestPhys_i(exeDestPhys0_i),
                .exeAlIndex_i(exeAlIndex0_i), .exeData_i(exeData0_i),
                .squash_i(ctrlMispredict_o), .squashCheckpoint_i(ctrlCheckpoint_o),
                .writebkValid_o(writebkValid0_o), .bypassValid_o(bypassValid0_o),
                .bypassPhys_o(bypassPhys0_o), .bypassData_o(bypassData0_o),
                .alIndex_o(alIndex0)
        );

        wbLane lane1
        (
                .clk(clk), .reset(reset),
                .exeValid_i(exeValid1_i), .exeBranchMask_i(exeBranchMask1_i),
                .exeWritesReg_i(exeWritesReg1_i), .exeDestPhys_i(exeDestPhys1_i),
                .exeAlIndex_i(exeAlIndex1_i), .exeData_i(exeData1_i),
                .squash_i(ctrlMispredict_o), .squashCheckpoint_i(ctrlCheckpoint_o),
                .writebkValid_o(writebkValid1_o), .bypassValid_o(bypassValid1_o),
                .bypassPhys_o(bypassPhys1_o), .bypassData_o(bypassData1_o),
                .alIndex_o(alIndex1)
        );

        wbLane lane2
        (
                .clk(clk), .reset(reset),
                .exeValid_i(exeValid2_i), .exeBranchMask_i(exeBranchMask2_i),
                .exeWritesReg_i(exeWritesReg2_i), .exeDestPhys_i(exeDestPhys2_i),
                .exeAlIndex_i(exeAlIndex2_i), .exeData_i(exeData2_i),
                .squash_i(ctrlMispredict_o), .squashCheckpoint_i(ctrlCheckpoint_o),
                .writebkValid_o(writebkValid2_o), .bypassValid_o(bypassValid2_o),
                .bypassPhys_o(bypassPhys2_o), .bypassData_o(bypassData2_o),
                .alIndex_o(alIndex2)
        );

        wbLane lane3
        (
                .clk(clk), .reset(reset),
                .exeValid_i(exeValid3_i), .exeBranchMask_i(exeBranchMask3_i),
                .exeWritesReg_i(exeWritesReg3_i), .exeDestPhys_i(exeDestPhys3_i),
                .exeAlIndex_i(exeAlIndex3_i), .exeData_i(exeData3_i),
                .squash_i(ctrlMispredict_o), .squashCheckpoint_i(ctrlCheckpoint_o),
                .writebkValid_o(writebkValid3_o), .bypassValid_o(bypassValid3_o),
                .bypassPhys_o(bypassPhys3_o), .bypassData_o(bypassData3_o),
                .alIndex_o(alIndex3)
        );

        // the branch operands ride along with lane 2.
        branchResolve resolver
        (
                .clk(clk), .reset(reset),
                .brValid_i(exeValid2_i), .brCheckpoint_i(brCheckpoint_i),
                .brTaken_i(brTaken_i), .brTarget_i(brTarget_i),
                .brPredTaken_i(brPredTaken_i), .brPredTarget_i(brPredTarget_i),
                .ctrlVerified_o(ctrlVerified_o), .ctrlMispredict_o(ctrlMispredict_o),
                .ctrlCheckpoint_o(ctrlCheckpoint_o), .ctrlTarget_o(ctrlTarget_o),
                .ctrlTaken_o(ctrlTaken_o)
        );

        completionQueue
        #(
                .QUEUE_DEPTH(QUEUE_DEPTH),
                .INIT_CREDITS(INIT_CREDITS)
        )
        cmplQueue
        (
                .clk(clk), .reset(reset),
                .laneValid_i({writebkValid3_o, writebkValid2_o,
                              writebkValid1_o, writebkValid0_o}),
                .laneAlIndex0_i(alIndex0), .laneAlIndex1_i(alIndex1),
                .laneAlIndex2_i(alIndex2), .laneAlIndex3_i(alIndex3),
                .brMispredict_i(ctrlMispredict_o), .creditReturn_i(creditReturn_i),
                .cmplValid_o(cmplValid_o), .cmplAlIndex_o(cmplAlIndex_o),
                .cmplKind_o(cmplKind_o)
        );

endmodule

`default_nettype wire

/* tests/tbWriteBack.sv */
// Writeback stage testbench with a stimulus table, a reference model of the
// lanes, branch resolution and completion channel, and the checks.
`timescale 1ns/1ps
`default_nettype none

module tbWriteBack;

        localparam int NROWS = 24;
        localparam int QUEUE_DEPTH = 8;
        localparam int INIT_CREDITS = 4;

        logic clk;
        logic reset;
        logic [3:0] exeValid;
        logic [3:0][3:0] exeMask;
        logic [3:0] exeWr;
        logic [3:0][5:0] exePhys;
        logic [3:0][4:0] exeAl;
        logic [3:0][31:0] exeData;
        logic [1:0] brCheckpoint;
        logic brTaken;
        logic brPredTaken;
        logic [31:0] brTarget;
        logic [31:0] brPredTarget;
        logic creditReturn;
        wire [3:0] bypassValid;
        wire [3:0] writebkValid;
        wire [3:0][5:0] bypassPhys;
        wire [3:0][31:0] bypassData;
        logic ctrlVerified;
        logic ctrlMispredict;
        logic ctrlTaken;
        logic cmplValid;
        logic [1:0] ctrlCheckpoint;
        logic [31:0] ctrlTarget;
        logic [4:0] cmplAlIndex;
        wbPkg::cmplKind_e cmplKind;

        // the stimulus table holds one entry per cycle and entry NROWS is the idle drain row.
        logic [3:0] tValid [NROWS+1];
        logic [15:0] tMask [NROWS+1];
        logic [3:0] tWr [NROWS+1];
        logic [1:0] tCp [NROWS+1];
        logic tTk [NROWS+1];
        logic tPtk [NROWS+1];
        logic tTdiff [NROWS+1];
        logic tCr [NROWS+1];
        logic tMisp [NROWS+1];
        logic [31:0] tTarget [NROWS+1];
        logic [3:0][5:0] tPhys [NROWS+1];
        logic [3:0][4:0] tAl [NROWS+1];
        logic [3:0][31:0] tData [NROWS+1];

        logic [4:0] expAl [$];
        wbPkg::cmplKind_e expKind [$];
        logic [4:0] stageAl [$];
        wbPkg::cmplKind_e stageKind [$];
        int seed = 32'h28fbbc47;
        int credits;
        int prev;
        int errors;
        int received;
        int cycles;
        int flush;
        logic [4:0] alNext;

        writeBack #(.QUEUE_DEPTH(QUEUE_DEPTH), .INIT_CREDITS(INIT_CREDITS)) UUT
        (
                .clk(clk), .reset(reset),
                .exeValid0_i(exeValid[0]), .exeBranchMask0_i(exeMask[0]),
                .exeWritesReg0_i(exeWr[0]), .exeDestPhys0_i(exePhys[0]),
                .exeAlIndex0_i(exeAl[0]), .exeData0_i(exeData[0]),
                .exeValid1_i(exeValid[1]), .exeBranchMask1_i(exeMask[1]),
                .exeWritesReg1_i(exeWr[1]), .exeDestPhys1_i(exePhys[1]),
                .exeAlIndex1_i(exeAl[1]), .exeData1_i(exeData[1]),
                .exeValid2_i(exeValid[2]), .exeBranchMask2_i(exeMask[2]),
                .exeWritesReg2_i(exeWr[2]), .exeDestPhys2_i(exePhys[2]),
                .exeAlIndex2_i(exeAl[2]), .exeData2_i(exeData[2]),
                .exeValid3_i(exeValid[3]), .exeBranchMask3_i(exeMask[3]),
                .exeWritesReg3_i(exeWr[3]), .exeDestPhys3_i(exePhys[3]),
                .exeAlIndex3_i(exeAl[3]), .exeData3_i(exeData[3]),
                .brCheckpoint_i(brCheckpoint), .brTaken_i(brTaken), .brTarget_i(brTarget),
                .brPredTaken_i(brPredTaken), .brPredTarget_i(brPredTarget),
                .creditReturn_i(creditReturn),
                .bypassValid0_o(bypassValid[0]), .bypassPhys0_o(bypassPhys[0]),
                .bypassData0_o(bypassData[0]), .writebkValid0_o(writebkValid[0]),
                .bypassValid1_o(bypassValid[1]), .bypassPhys1_o(bypassPhys[1]),
                .bypassData1_o(bypassData[1]), .writebkValid1_o(writebkValid[1]),
                .bypassValid2_o(bypassValid[2]), .bypassPhys2_o(bypassPhys[2]),
                .bypassData2_o(bypassData[2]), .writebkValid2_o(writebkValid[2]),
                .bypassValid3_o(bypassValid[3]), .bypassPhys3_o(bypassPhys[3]),
                .bypassData3_o(bypassData[3]), .writebkValid3_o(writebkValid[3]),
                .ctrlVerified_o(ctrlVerified), .ctrlMispredict_o(ctrlMispredict),
                .ctrlCheckpoint_o(ctrlCheckpoint), .ctrlTarget_o(ctrlTarget),
                .ctrlTaken_o(ctrlTaken), .cmplValid_o(cmplValid),
                .cmplAlIndex_o(cmplAlIndex), .cmplKind_o(cmplKind)
        );

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycles = cycles + 1;
                if (cycles > NROWS + 40)
                begin
                        $display("timeout: run still busy after %0d cycles", cycles);
                        $display("** FAIL **");
                        $finish;
                end
        end

        // ------------------------------
        // table and drive
        // ------------------------------
        task automatic setRow(input int r, input logic [3:0] v, input logic [15:0] m,
                input logic [3:0] wr, input logic [1:0] cp, input logic tk, input logic ptk,
                input logic td, input logic cr, input logic mp);
                tValid[r] = v;
                tMask[r] = m;
                tWr[r] = wr;
                tCp[r] = cp;
                tTk[r] = tk;
                tPtk[r] = ptk;
                tTdiff[r] = td;
                tCr[r] = cr;
                tMisp[r] = mp;
        endtask

        task automatic driveRow(input int r);
                int n;
                for (n = 0; n < 4; n++)
                begin
                        exeValid[n] = tValid[r][n];
                        exeMask[n] = tMask[r][4*n +: 4];
                        exeWr[n] = tWr[r][n];
                        exePhys[n] = tPhys[r][n];
                        exeAl[n] = tAl[r][n];
                        exeData[n] = tData[r][n];
                end
                brCheckpoint = tCp[r];
                brTaken = tTk[r];
                brPredTaken = tPtk[r];
                brTarget = tTarget[r];
                brPredTarget = tTdiff[r] ? (tTarget[r] ^ 32'h40) : tTarget[r];
                // the active list only hands back credits it actually holds.
                creditReturn = tCr[r] && (credits < INIT_CREDITS);
        endtask

        task automatic reportMismatch(input string what, input logic [31:0] got,
                input logic [31:0] exp);
                errors = errors + 1;
                $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        endtask

        // ------------------------------
        // model and checks
        // ------------------------------
        task automatic checkCycle();
                int n;
                logic kill;
                logic wbExp;
                logic expValid;
                wbPkg::cmplKind_e kind;
                while (stageAl.size() != 0)
                begin
                        expAl.push_back(stageAl.pop_front());
                        expKind.push_back(stageKind.pop_front());
                end
                expValid = (expAl.size() != 0) && (credits != 0);
                if (cmplValid !== expValid)
                        reportMismatch("completion valid", cmplValid, expValid);
                if (cmplValid && expValid)
                begin
                        if (cmplAlIndex !== expAl[0])
                                reportMismatch("completion AL index", cmplAlIndex, expAl[0]);
                        if (cmplKind !== expKind[0])
                                reportMismatch("completion kind", cmplKind, expKind[0]);
                        void'(expAl.pop_front());
                        void'(expKind.pop_front());
                        received = received + 1;
                end
                for (n = 0; n < 4; n++)
                begin
                        kill = tMisp[prev] && tMask[prev][4*n + tCp[prev]];
                        wbExp = tValid[prev][n] && !kill;
                        if (writebkValid[n] !== wbExp)
                                reportMismatch($sformatf("lane %0d writeback valid", n),
                                        writebkValid[n], wbExp);
                        if (bypassValid[n] !== (wbExp && tWr[prev][n]))
                                reportMismatch($sformatf("lane %0d bypass valid", n),
                                        bypassValid[n], wbExp && tWr[prev][n]);
                        if (wbExp)
                        begin
                                if (bypassPhys[n] !== tPhys[prev][n])
                                        reportMismatch("bypass phys", bypassPhys[n], tPhys[prev][n]);
                                if (bypassData[n] !== tData[prev][n])
                                        reportMismatch("bypass data", bypassData[n], tData[prev][n]);
                                if (n != wbPkg::BRANCH_LANE)
                                        kind = wbPkg::CMPL_NORMAL;
                                else if (tMisp[prev])
                                        kind = wbPkg::CMPL_MISPREDICT;
                                else
                                        kind = wbPkg::CMPL_BRANCH_OK;
                                stageAl.push_back(tAl[prev][n]);
                                stageKind.push_back(kind);
                        end
                end
                if (ctrlVerified !== tValid[prev][2])
                        reportMismatch("branch verified", ctrlVerified, tValid[prev][2]);
                if (ctrlMispredict !== tMisp[prev])
                        reportMismatch("branch mispredict", ctrlMispredict, tMisp[prev]);
                if (tValid[prev][2])
                begin
                        if (ctrlCheckpoint !== tCp[prev])
                                reportMismatch("branch checkpoint", ctrlCheckpoint, tCp[prev]);
                        if (ctrlTaken !== tTk[prev])
                                reportMismatch("branch taken", ctrlTaken, tTk[prev]);
                        if (ctrlTarget !== tTarget[prev])
                                reportMismatch("branch target", ctrlTarget, tTarget[prev]);
                end
                credits = credits + int'(creditReturn) - int'(expValid);
        endtask

        task automatic runCycle(input int r);
                @(posedge clk);
                #1;
                driveRow(r);
                @(negedge clk);
                checkCycle();
                prev = r;
        endtask

        initial
        begin
                errors = 0;
                received = 0;
                cycles = 0;
                credits = INIT_CREDITS;
                prev = NROWS;
                alNext = '0;
                for (int r = 0; r <= NROWS; r++)
                        setRow(r, 4'b0000, 16'h0000, 4'b0000, 2'd0, 0, 0, 0, 1'b1, 0);
                setRow(1, 4'b0011, 16'h0000, 4'b0001, 2'd0, 0, 0, 0, 1'b0, 0);
                setRow(2, 4'b1111, 16'h1000, 4'b1011, 2'd0, 1, 1, 0, 1'b0, 0);
                setRow(4, 4'b0111, 16'h0002, 4'b0011, 2'd1, 1, 0, 0, 1'b0, 1);
                setRow(5, 4'b1101, 16'h4004, 4'b1001, 2'd2, 1, 1, 1, 1'b0, 1);
                setRow(6, 4'b1010, 16'h0000, 4'b1010, 2'd0, 0, 0, 0, 1'b0, 0);
                // rows 0 to 7 withhold credits so the queue backs up.
                for (int r = 0; r < 8; r++)
                        tCr[r] = 1'b0;
                setRow(11, 4'b1111, 16'h0008, 4'b1011, 2'd3, 0, 0, 1, 1'b1, 0);
                setRow(13, 4'b0100, 16'h0000, 4'b0000, 2'd3, 0, 1, 0, 1'b1, 1);
                setRow(14, 4'b1001, 16'h1008, 4'b1001, 2'd0, 0, 0, 0, 1'b1, 0);
                setRow(17, 4'b0111, 16'h0021, 4'b0011, 2'd0, 1, 1, 0, 1'b1, 0);
                setRow(19, 4'b1110, 16'h4080, 4'b1010, 2'd3, 1, 1, 1, 1'b1, 1);
                setRow(20, 4'b0000, 16'h0000, 4'b0000, 2'd0, 0, 0, 0, 1'b0, 0);
                setRow(21, 4'b0000, 16'h0000, 4'b0000, 2'd0, 0, 0, 0, 1'b0, 0);
                // AL indices follow issue order and the data and targets are random.
                for (int r = 0; r <= NROWS; r++)
                begin
                        tTarget[r] = $random(seed);
                        for (int n = 0; n < 4; n++)
                        begin
                                tPhys[r][n] = $random(seed);
                                tData[r][n] = $random(seed);
                                tAl[r][n] = tValid[r][n] ? alNext : 5'd0;
                                alNext = alNext + 5'(tValid[r][n]);
                        end
                end
                reset = 1'b1;
                driveRow(NROWS);
                creditReturn = 1'b0;
                repeat (3) @(posedge clk);
                #1;
                reset = 1'b0;
                for (int r = 0; r < NROWS; r++)
                        runCycle(r);
                flush = 0;
                while (flush < 2 || expAl.size() != 0 || stageAl.size() != 0)
                begin
                        runCycle(NROWS);
                        flush = flush + 1;
                end
                $display("rows %0d, completions %0d, errors %0d", NROWS, received, errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire

/* sim.f */
hdl/wbPkg.sv
hdl/wbLane.sv
hdl/branchResolve.sv
hdl/completionQueue.sv
hdl/writeBack.sv
tests/tbWriteBack.sv

/* Bender.yml */
package:
  name: writeback_stage

sources:
  - hdl/wbPkg.sv
  - hdl/wbLane.sv
  - hdl/branchResolve.sv
  - hdl/completionQueue.sv
  - hdl/writeBack.sv
  - target: simulation
    files:
      - tests/tbWriteBack.sv
